/* common/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    // alu operations carried from decode to execute
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_e;

    // 3R and shift-immediate forms, inst[31:15]
    localparam logic [16:0] OP_ADD_W  = 17'h00020;
    localparam logic [16:0] OP_SUB_W  = 17'h00022;
    localparam logic [16:0] OP_SLT    = 17'h00024;
    localparam logic [16:0] OP_SLTU   = 17'h00025;
    localparam logic [16:0] OP_NOR    = 17'h00028;
    localparam logic [16:0] OP_AND    = 17'h00029;
    localparam logic [16:0] OP_OR     = 17'h0002a;
    localparam logic [16:0] OP_XOR    = 17'h0002b;
    localparam logic [16:0] OP_SLL_W  = 17'h0002e;
    localparam logic [16:0] OP_SRL_W  = 17'h0002f;
    localparam logic [16:0] OP_SRA_W  = 17'h00030;
    localparam logic [16:0] OP_SLLI_W = 17'h00081;
    localparam logic [16:0] OP_SRLI_W = 17'h00089;
    localparam logic [16:0] OP_SRAI_W = 17'h00091;

    // 2RI12 forms, inst[31:22]
    localparam logic [9:0] OP_SLTI   = 10'h008;
    localparam logic [9:0] OP_SLTUI  = 10'h009;
    localparam logic [9:0] OP_ADDI_W = 10'h00a;
    localparam logic [9:0] OP_ANDI   = 10'h00d;
    localparam logic [9:0] OP_ORI    = 10'h00e;
    localparam logic [9:0] OP_XORI   = 10'h00f;

    // 1RI20 form, inst[31:25]
    localparam logic [6:0] OP_LU12I_W = 7'h0a;

endpackage

`default_nettype wire

/* decode/regfile.sv */
`default_nettype none

module regfile import cpu_pkg::*; (
    input  wire                   aclk,
    input  wire                   rst_n,
    input  wire [REG_ADDR_W-1:0]  raddr1,
    input  wire [REG_ADDR_W-1:0]  raddr2,
    output logic [XLEN-1:0]       rdata1,
    output logic [XLEN-1:0]       rdata2,
    input  wire                   we,
    input  wire [REG_ADDR_W-1:0]  waddr,
    input  wire [XLEN-1:0]        wdata
);

    logic [XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++)
                regs[i] <= '0;
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 reads zero whatever is stored
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

    // decode drops rd == 0 writes long before they get here
    a_no_r0_write: assert property (@(posedge aclk) disable iff (!rst_n)
        we |-> waddr != '0);

endmodule

`default_nettype wire

/* decode/decode_stage.sv */
`default_nettype none

module decode_stage import cpu_pkg::*; (
    input  wire                   aclk,
    input  wire                   rst_n,
    input  wire                   inst_valid,
    input  wire [31:0]            inst,
    input  wire [XLEN-1:0]        inst_pc,
    // register file read
    output logic [REG_ADDR_W-1:0] rf_raddr1,
    output logic [REG_ADDR_W-1:0] rf_raddr2,
    input  wire [XLEN-1:0]        rf_rdata1,
    input  wire [XLEN-1:0]        rf_rdata2,
    // execute forwarding
    input  wire                   es_valid,
    input  wire                   es_we,
    input  wire [REG_ADDR_W-1:0]  es_dest,
    input  wire [XLEN-1:0]        es_result,
    // writeback forwarding
    input  wire                   rf_we,
    input  wire [REG_ADDR_W-1:0]  rf_waddr,
    input  wire [XLEN-1:0]        rf_wdata,
    // to execute
    output logic                  ds_valid,
    output alu_op_e               ds_alu_op,
    output logic [XLEN-1:0]       ds_src1,
    output logic [XLEN-1:0]       ds_src2,
    output logic [REG_ADDR_W-1:0] ds_dest,
    output logic                  ds_we,
    output logic [XLEN-1:0]       ds_pc
);

    logic        ir_valid;
    logic [31:0] ir_inst;
    logic [XLEN-1:0] ir_pc;

    logic [16:0] op_31_15;
    logic [9:0]  op_31_22;
    logic [6:0]  op_31_25;
    logic [REG_ADDR_W-1:0] rj;
    logic [REG_ADDR_W-1:0] rk;
    logic reg_form;
    logic shift_imm;
    logic sext_imm;
    logic zext_imm;
    logic is_lu12i;
    logic dec_ok;
    logic [XLEN-1:0] rj_val;
    logic [XLEN-1:0] rk_val;

    // execute result first, then writeback, then the array
    function automatic logic [XLEN-1:0] fwd(input logic [REG_ADDR_W-1:0] ra,
                                            input logic [XLEN-1:0] arr_val);
        if (ra == '0)
            return '0;
        else if (es_valid && es_we && es_dest == ra)
            return es_result;
        else if (rf_we && rf_waddr == ra)
            return rf_wdata;
        else
            return arr_val;
    endfunction

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n)
            ir_valid <= 1'b0;
        else
            ir_valid <= inst_valid;
    end

    always_ff @(posedge aclk) begin
        if (inst_valid) begin
            ir_inst <= inst;
            ir_pc   <= inst_pc;
        end
    end

    assign op_31_15 = ir_inst[31:15];
    assign op_31_22 = ir_inst[31:22];
    assign op_31_25 = ir_inst[31:25];
    assign rj       = ir_inst[9:5];
    assign rk       = ir_inst[14:10];

    assign reg_form  = op_31_15 inside {OP_ADD_W, OP_SUB_W, OP_SLT, OP_SLTU, OP_NOR, OP_AND,
                                        OP_OR, OP_XOR, OP_SLL_W, OP_SRL_W, OP_SRA_W};
    assign shift_imm = op_31_15 inside {OP_SLLI_W, OP_SRLI_W, OP_SRAI_W};
    assign sext_imm  = op_31_22 inside {OP_SLTI, OP_SLTUI, OP_ADDI_W};
    assign zext_imm  = op_31_22 inside {OP_ANDI, OP_ORI, OP_XORI};
    assign is_lu12i  = op_31_25 == OP_LU12I_W;
    assign dec_ok    = reg_form | shift_imm | sext_imm | zext_imm | is_lu12i;

    // opcode groups do not overlap, add is the fallback
    always_comb begin
        ds_alu_op = ALU_ADD;
        case (op_31_15)
            OP_SUB_W:             ds_alu_op = ALU_SUB;
            OP_SLT:               ds_alu_op = ALU_SLT;
            OP_SLTU:              ds_alu_op = ALU_SLTU;
            OP_NOR:               ds_alu_op = ALU_NOR;
            OP_AND:               ds_alu_op = ALU_AND;
            OP_OR:                ds_alu_op = ALU_OR;
            OP_XOR:               ds_alu_op = ALU_XOR;
            OP_SLL_W, OP_SLLI_W:  ds_alu_op = ALU_SLL;
            OP_SRL_W, OP_SRLI_W:  ds_alu_op = ALU_SRL;
            OP_SRA_W, OP_SRAI_W:  ds_alu_op = ALU_SRA;
            default:              ds_alu_op = ALU_ADD;
        endcase
        case (op_31_22)
            OP_SLTI:  ds_alu_op = ALU_SLT;
            OP_SLTUI: ds_alu_op = ALU_SLTU;
            OP_ANDI:  ds_alu_op = ALU_AND;
            OP_ORI:   ds_alu_op = ALU_OR;
            OP_XORI:  ds_alu_op = ALU_XOR;
            default:  ;
        endcase
        if (is_lu12i)
            ds_alu_op = ALU_LUI;
    end

    always_comb begin
        rj_val = fwd(rj, rf_rdata1);
        rk_val = fwd(rk, rf_rdata2);
    end

    always_comb begin
        if (reg_form)
            ds_src2 = rk_val;
        else if (shift_imm)
            ds_src2 = {{(XLEN-5){1'b0}}, ir_inst[14:10]};
        else if (zext_imm)
            ds_src2 = {{(XLEN-12){1'b0}}, ir_inst[21:10]};
        else if (is_lu12i)
            ds_src2 = {ir_inst[24:5], 12'b0};
        else
            ds_src2 = {{(XLEN-12){ir_inst[21]}}, ir_inst[21:10]};
    end

    assign rf_raddr1 = rj;
    assign rf_raddr2 = rk;
    assign ds_valid  = ir_valid;
    assign ds_src1   = rj_val;
    assign ds_dest   = ir_inst[4:0];
    assign ds_we     = dec_ok && (ir_inst[4:0] != '0);
    assign ds_pc     = ir_pc;

    a_ds_valid_known: assert property (@(posedge aclk) disable iff (!rst_n)
        !$isunknown(ds_valid));

endmodule

`default_nettype wire

/* execute/execute_stage.sv */
`default_nettype none

module execute_stage import cpu_pkg::*; (
    input  wire                   aclk,
    input  wire                   rst_n,
    input  wire                   ds_valid,
    input  alu_op_e               ds_alu_op,
    input  wire [XLEN-1:0]        ds_src1,
    input  wire [XLEN-1:0]        ds_src2,
    input  wire [REG_ADDR_W-1:0]  ds_dest,
    input  wire                   ds_we,
    input  wire [XLEN-1:0]        ds_pc,
    output logic                  es_valid,
    output logic                  es_we,
    output logic [REG_ADDR_W-1:0] es_dest,
    output logic [XLEN-1:0]       es_result,
    output logic [XLEN-1:0]       es_pc
);

    alu_op_e         es_op;
    logic [XLEN-1:0] es_src1;
    logic [XLEN-1:0] es_src2;
    logic [4:0]      shamt;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n)
            es_valid <= 1'b0;
        else
            es_valid <= ds_valid;
    end

    always_ff @(posedge aclk) begin
        if (ds_valid) begin
            es_op   <= ds_alu_op;
            es_src1 <= ds_src1;
            es_src2 <= ds_src2;
            es_dest <= ds_dest;
            es_we   <= ds_we;
            es_pc   <= ds_pc;
        end
    end

    // low five bits for both shift forms
    assign shamt = es_src2[4:0];

    always_comb begin
        case (es_op)
            ALU_ADD:  es_result = es_src1 + es_src2;
            ALU_SUB:  es_result = es_src1 - es_src2;
            ALU_SLT:  es_result = {{(XLEN-1){1'b0}}, $signed(es_src1) < $signed(es_src2)};
            ALU_SLTU: es_result = {{(XLEN-1){1'b0}}, es_src1 < es_src2};
            ALU_AND:  es_result = es_src1 & es_src2;
            ALU_OR:   es_result = es_src1 | es_src2;
            ALU_XOR:  es_result = es_src1 ^ es_src2;
            ALU_NOR:  es_result = ~(es_src1 | es_src2);
            ALU_SLL:  es_result = es_src1 << shamt;
            ALU_SRL:  es_result = es_src1 >> shamt;
            ALU_SRA:  es_result = $unsigned($signed(es_src1) >>> shamt);
            // immediate already shifted up in decode
            ALU_LUI:  es_result = es_src2;
            default:  es_result = '0;
        endcase
    end

    a_es_op_legal: assert property (@(posedge aclk) disable iff (!rst_n)
        es_valid |-> es_op inside {ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND, ALU_OR,
                                   ALU_XOR, ALU_NOR, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI});

endmodule

`default_nettype wire

/* verilog/writeback_stage.sv */
`default_nettype none

module writeback_stage import cpu_pkg::*; (
    input  wire                   aclk,
    input  wire                   rst_n,
    input  wire                   es_valid,
    input  wire                   es_we,
    input  wire [REG_ADDR_W-1:0]  es_dest,
    input  wire [XLEN-1:0]        es_result,
    input  wire [XLEN-1:0]        es_pc,
    output logic                  rf_we,
    output logic [REG_ADDR_W-1:0] rf_waddr,
    output logic [XLEN-1:0]       rf_wdata,
    output logic [XLEN-1:0]       debug_wb_pc,
    output logic                  debug_wb_rf_we,
    output logic [REG_ADDR_W-1:0] debug_wb_rf_wnum,
    output logic [XLEN-1:0]       debug_wb_rf_wdata
);

    logic                  ws_valid;
    logic                  ws_we;
    logic [REG_ADDR_W-1:0] ws_dest;
    logic [XLEN-1:0]       ws_result;
    logic [XLEN-1:0]       ws_pc;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n)
            ws_valid <= 1'b0;
        else
            ws_valid <= es_valid;
    end

    always_ff @(posedge aclk) begin
        if (es_valid) begin
            ws_we     <= es_we;
            ws_dest   <= es_dest;
            ws_result <= es_result;
            ws_pc     <= es_pc;
        end
    end

    // one register feeds the array, forwarding and trace
    assign rf_we    = ws_valid && ws_we;
    assign rf_waddr = ws_dest;
    assign rf_wdata = ws_result;

    assign debug_wb_pc       = ws_pc;
    assign debug_wb_rf_we    = rf_we;
    assign debug_wb_rf_wnum  = ws_dest;
    assign debug_wb_rf_wdata = ws_result;

    a_trace_no_r0: assert property (@(posedge aclk) disable iff (!rst_n)
        debug_wb_rf_we |-> debug_wb_rf_wnum != '0);

endmodule

`default_nettype wire

/* verilog/cpu_top.sv */
`default_nettype none

module cpu_top import cpu_pkg::*; (
    input  wire                  aclk,
    input  wire                  rst_n,
    input  wire                  inst_valid,
    input  wire [31:0]           inst,
    input  wire [XLEN-1:0]       inst_pc,
    // writeback trace
    output wire [XLEN-1:0]       debug_wb_pc,
    output wire                  debug_wb_rf_we,
    output wire [REG_ADDR_W-1:0] debug_wb_rf_wnum,
    output wire [XLEN-1:0]       debug_wb_rf_wdata
);

    wire [REG_ADDR_W-1:0] rf_raddr1;
    wire [REG_ADDR_W-1:0] rf_raddr2;
    wire [XLEN-1:0]       rf_rdata1;
    wire [XLEN-1:0]       rf_rdata2;

    wire                  ds_valid;
    alu_op_e              ds_alu_op;
    wire [XLEN-1:0]       ds_src1;
    wire [XLEN-1:0]       ds_src2;
    wire [REG_ADDR_W-1:0] ds_dest;
    wire                  ds_we;
    wire [XLEN-1:0]       ds_pc;

    wire                  es_valid;
    wire                  es_we;
    wire [REG_ADDR_W-1:0] es_dest;
    wire [XLEN-1:0]       es_result;
    wire [XLEN-1:0]       es_pc;

    // writeback port, also the second forwarding source
    wire                  rf_we;
    wire [REG_ADDR_W-1:0] rf_waddr;
    wire [XLEN-1:0]       rf_wdata;

    decode_stage u_decode_stage (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .inst_valid (inst_valid),
        .inst       (inst),
        .inst_pc    (inst_pc),
        .rf_raddr1  (rf_raddr1),
        .rf_raddr2  (rf_raddr2),
        .rf_rdata1  (rf_rdata1),
        .rf_rdata2  (rf_rdata2),
        .es_valid   (es_valid),
        .es_we      (es_we),
        .es_dest    (es_dest),
        .es_result  (es_result),
        .rf_we      (rf_we),
        .rf_waddr   (rf_waddr),
        .rf_wdata   (rf_wdata),
        .ds_valid   (ds_valid),
        .ds_alu_op  (ds_alu_op),
        .ds_src1    (ds_src1),
        .ds_src2    (ds_src2),
        .ds_dest    (ds_dest),
        .ds_we      (ds_we),
        .ds_pc      (ds_pc)
    );

    regfile u_regfile (
        .aclk   (aclk),
        .rst_n  (rst_n),
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

    execute_stage u_execute_stage (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .ds_valid  (ds_valid),
        .ds_alu_op (ds_alu_op),
        .ds_src1   (ds_src1),
        .ds_src2   (ds_src2),
        .ds_dest   (ds_dest),
        .ds_we     (ds_we),
        .ds_pc     (ds_pc),
        .es_valid  (es_valid),
        .es_we     (es_we),
        .es_dest   (es_dest),
        .es_result (es_result),
        .es_pc     (es_pc)
    );

    writeback_stage u_writeback_stage (
        .aclk              (aclk),
        .rst_n             (rst_n),
        .es_valid          (es_valid),
        .es_we             (es_we),
        .es_dest           (es_dest),
        .es_result         (es_result),
        .es_pc             (es_pc),
        .rf_we             (rf_we),
        .rf_waddr          (rf_waddr),
        .rf_wdata          (rf_wdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

endmodule

`default_nettype wire

/* verification/cpu_ref_model.svh */
`ifndef CPU_REF_MODEL_SVH
`define CPU_REF_MODEL_SVH

// one expected trace entry, due before edge_no
typedef struct {
    logic [XLEN-1:0]       pc;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       val;
    int unsigned           edge_no;
} wb_entry_t;

logic [XLEN-1:0] arch_regs [NUM_REGS];
wb_entry_t       exp_q [$];

// op index 0..10 register forms, 11..13 shift imm, 14..19 imm12, 20 lu12i.w
function automatic logic [31:0] encode(input int op, input logic [4:0] rd,
                                       input logic [4:0] rj, input logic [4:0] rk,
                                       input logic [19:0] imm);
    logic [31:0] w;
    case (op)
        0:       w = {OP_ADD_W, rk, rj, rd};
        1:       w = {OP_SUB_W, rk, rj, rd};
        2:       w = {OP_SLT, rk, rj, rd};
        3:       w = {OP_SLTU, rk, rj, rd};
        4:       w = {OP_AND, rk, rj, rd};
        5:       w = {OP_OR, rk, rj, rd};
        6:       w = {OP_XOR, rk, rj, rd};
        7:       w = {OP_NOR, rk, rj, rd};
        8:       w = {OP_SLL_W, rk, rj, rd};
        9:       w = {OP_SRL_W, rk, rj, rd};
        10:      w = {OP_SRA_W, rk, rj, rd};
        11:      w = {OP_SLLI_W, imm[4:0], rj, rd};
        12:      w = {OP_SRLI_W, imm[4:0], rj, rd};
        13:      w = {OP_SRAI_W, imm[4:0], rj, rd};
        14:      w = {OP_ADDI_W, imm[11:0], rj, rd};
        15:      w = {OP_SLTI, imm[11:0], rj, rd};
        16:      w = {OP_SLTUI, imm[11:0], rj, rd};
        17:      w = {OP_ANDI, imm[11:0], rj, rd};
        18:      w = {OP_ORI, imm[11:0], rj, rd};
        19:      w = {OP_XORI, imm[11:0], rj, rd};
        default: w = {OP_LU12I_W, imm, rd};
    endcase
    return w;
endfunction

// returns 0 for an undecoded word
function automatic bit model_exec(input logic [31:0] w, output logic [XLEN-1:0] val);
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] si;
    logic [XLEN-1:0] zi;
    logic [4:0]      sa;
    a  = arch_regs[w[9:5]];
    b  = arch_regs[w[14:10]];
    si = {{20{w[21]}}, w[21:10]};
    zi = {20'b0, w[21:10]};
    sa = w[14:10];
    val = '0;
    model_exec = 1'b1;
    if (w[31:25] == OP_LU12I_W) begin
        val = {w[24:5], 12'b0};
    end else begin
        case (w[31:15])
            OP_ADD_W:  val = a + b;
            OP_SUB_W:  val = a - b;
            OP_SLT:    val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            OP_SLTU:   val = (a < b) ? 32'd1 : 32'd0;
            OP_AND:    val = a & b;
            OP_OR:     val = a | b;
            OP_XOR:    val = a ^ b;
            OP_NOR:    val = ~(a | b);
            OP_SLL_W:  val = a << b[4:0];
            OP_SRL_W:  val = a >> b[4:0];
            OP_SRA_W:  val = $signed(a) >>> b[4:0];
            OP_SLLI_W: val = a << sa;
            OP_SRLI_W: val = a >> sa;
            OP_SRAI_W: val = $signed(a) >>> sa;
            default: begin
                case (w[31:22])
                    OP_ADDI_W: val = a + si;
                    OP_SLTI:   val = ($signed(a) < $signed(si)) ? 32'd1 : 32'd0;
                    // unsigned compare, but against the sign-extended immediate
                    OP_SLTUI:  val = (a < si) ? 32'd1 : 32'd0;
                    OP_ANDI:   val = a & zi;
                    OP_ORI:    val = a | zi;
                    OP_XORI:   val = a ^ zi;
                    default:   model_exec = 1'b0;
                endcase
            end
        endcase
    end
endfunction

function automatic void model_reset();
    for (int i = 0; i < NUM_REGS; i++)
        arch_regs[i] = '0;
    exp_q.delete();
endfunction

function automatic void model_retire(input logic [31:0] w, input logic [XLEN-1:0] pc,
                                     input int unsigned due_edge);
    logic [XLEN-1:0] val;
    wb_entry_t       e;
    if (model_exec(w, val) && w[4:0] != 5'd0) begin
        arch_regs[w[4:0]] = val;
        e.pc      = pc;
        e.rd      = w[4:0];
        e.val     = val;
        e.edge_no = due_edge;
        exp_q.push_back(e);
    end
endfunction

`endif

/* verification/cpu_tb.sv */
`default_nettype none

module cpu_tb import cpu_pkg::*; ();

    localparam int NUM_INSTS      = 2000;
    localparam int TIMEOUT_CYCLES = 4 * NUM_INSTS + 50;

    logic                  aclk;
    logic                  rst_n;
    logic                  inst_valid;
    logic [31:0]           inst;
    logic [XLEN-1:0]       inst_pc;
    wire [XLEN-1:0]        debug_wb_pc;
    wire                   debug_wb_rf_we;
    wire [REG_ADDR_W-1:0]  debug_wb_rf_wnum;
    wire [XLEN-1:0]        debug_wb_rf_wdata;

    int unsigned     edge_cnt = 0;
    int              issued;
    logic [XLEN-1:0] next_pc;
    logic [4:0]      last_dest [2];
    int              value_errs = 0;
    int              missing_errs = 0;
    int              extra_errs = 0;
    int              leftover_errs = 0;

`include "cpu_ref_model.svh"

    cpu_top u_cpu_top (
        .aclk              (aclk),
        .rst_n             (rst_n),
        .inst_valid        (inst_valid),
        .inst              (inst),
        .inst_pc           (inst_pc),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    initial begin
        aclk = 1'b0;
        forever #5 aclk = ~aclk;
    end

    always @(posedge aclk) begin
        edge_cnt <= edge_cnt + 1;
        if (edge_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: run still busy after %0d cycles", edge_cnt);
            $display("Errors found");
            $finish;
        end
    end

    // half the sources come from the last two destinations
    function automatic logic [4:0] pick_src();
        if ($urandom_range(1) == 0)
            return last_dest[$urandom_range(1)];
        return 5'($urandom_range(31));
    endfunction

    // the trace seen now must be the entry due at the coming edge
    task automatic check_trace();
        wb_entry_t head;
        if (exp_q.size() != 0 && exp_q[0].edge_no == edge_cnt + 1) begin
            head = exp_q.pop_front();
            assert (debug_wb_rf_we === 1'b1) else begin
                missing_errs++;
                $display("Fail at %0t: no write seen, expected pc %h r%0d = %h",
                         $time, head.pc, head.rd, head.val);
            end
            assert (debug_wb_pc === head.pc && debug_wb_rf_wnum === head.rd &&
                    debug_wb_rf_wdata === head.val) else begin
                value_errs++;
                $display("Fail at %0t: got pc %h r%0d = %h, expected pc %h r%0d = %h",
                         $time, debug_wb_pc, debug_wb_rf_wnum, debug_wb_rf_wdata,
                         head.pc, head.rd, head.val);
            end
        end else begin
            assert (debug_wb_rf_we === 1'b0) else begin
                extra_errs++;
                $display("Fail at %0t: unexpected write pc %h r%0d = %h",
                         $time, debug_wb_pc, debug_wb_rf_wnum, debug_wb_rf_wdata);
            end
        end
    endtask

    task automatic issue_random();
        int              op;
        logic [4:0]      rd;
        logic [31:0]     word;
        logic [XLEN-1:0] scratch;
        if ($urandom_range(15) == 0) begin
            do
                word = $urandom;
            while (model_exec(word, scratch));
        end else begin
            op   = $urandom_range(20);
            rd   = 5'($urandom_range(31));
            word = encode(op, rd, pick_src(), pick_src(), 20'($urandom));
            last_dest[1] = last_dest[0];
            last_dest[0] = rd;
        end
        inst_valid = 1'b1;
        inst       = word;
        inst_pc    = next_pc;
        // taken at the next edge, written three edges later
        model_retire(word, next_pc, edge_cnt + 4);
        next_pc = next_pc + 4;
        issued++;
    endtask

    initial begin
        void'($urandom(32'h50be_fdb8));
        rst_n        = 1'b0;
        inst_valid   = 1'b0;
        inst         = '0;
        inst_pc      = '0;
        issued       = 0;
        next_pc      = 32'h1c00_0000;
        last_dest[0] = 5'd0;
        last_dest[1] = 5'd0;
        model_reset();
        repeat (4) @(posedge aclk);
        @(negedge aclk);
        rst_n = 1'b1;

        while (issued < NUM_INSTS) begin
            @(negedge aclk);
            check_trace();
            if ($urandom_range(3) != 0)
                issue_random();
            else
                inst_valid = 1'b0;
        end
        // drain the pipe and watch for stray writes
        repeat (8) begin
            @(negedge aclk);
            check_trace();
            inst_valid = 1'b0;
        end

        assert (exp_q.size() == 0) else begin
            leftover_errs = exp_q.size();
            $display("%0d expected writebacks never appeared", leftover_errs);
        end
        $display("error counts: %0d value, %0d missing, %0d unexpected, %0d leftover",
                 value_errs, missing_errs, extra_errs, leftover_errs);
        if (value_errs + missing_errs + extra_errs + leftover_errs == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+verification
common/cpu_pkg.sv
decode/regfile.sv
decode/decode_stage.sv
execute/execute_stage.sv
verilog/writeback_stage.sv
verilog/cpu_top.sv
verification/cpu_tb.sv

/* Bender.yml */
package:
  name: cpu_core

sources:
  - common/cpu_pkg.sv
  - decode/regfile.sv
  - decode/decode_stage.sv
  - execute/execute_stage.sv
  - verilog/writeback_stage.sv
  - verilog/cpu_top.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/cpu_tb.sv
